// File: Bender.yml
package:
  name: ex_top

sources:
  - source/ex_pkg.sv
  - source/ex_req_if.sv
  - source/alu_int.sv
  - source/alu_muldiv.sv
  - source/branch_jump_unit.sv
  - source/ex_stage.sv
  - source/ex_top.sv
  - target: test
    files:
      - bench/ex_ref_pkg.sv
      - bench/ex_tb.sv

// File: bench/ex_ref_pkg.sv
package ex_ref_pkg;
   import ex_pkg::*;

   typedef logic [XLEN_DEF-1:0] word_t;

   localparam int    SHW     = $clog2(XLEN_DEF);
   localparam word_t ONES    = '1;
   localparam word_t MIN_INT = word_t'(1) << (XLEN_DEF - 1);

   // signed order is the unsigned order with the sign bits flipped.
   function automatic logic less_signed(word_t a, word_t b);
      return (a ^ MIN_INT) < (b ^ MIN_INT);
   endfunction

   function automatic word_t shift_right_arith(word_t a, word_t b);
      word_t fill;
      fill = a[XLEN_DEF-1] ? ~(ONES >> b[SHW-1:0]) : '0;
      return (a >> b[SHW-1:0]) | fill;
   endfunction

   // upper half of the 64-bit product.
   function automatic word_t mul_high(word_t a, word_t b, logic a_sgn, logic b_sgn);
      longint      x;
      longint      y;
      logic [63:0] p;
      x = a_sgn ? longint'($signed(a)) : longint'(a);
      y = b_sgn ? longint'($signed(b)) : longint'(b);
      p = x * y;
      return p[63:32];
   endfunction

   function automatic word_t divide(word_t a, word_t b, logic sgn, logic want_rem);
      int q;
      int r;
      if (b == '0) begin
         return want_rem ? a : ONES;
      end
      // most negative over minus one overflows.
      if (sgn && a == MIN_INT && b == ONES) begin
         return want_rem ? '0 : a;
      end
      if (sgn) begin
         q = $signed(a) / $signed(b);
         r = $signed(a) % $signed(b);
         return want_rem ? word_t'(r) : word_t'(q);
      end
      return want_rem ? a % b : a / b;
   endfunction

   function automatic word_t expected_result(ex_op_e op, word_t a, word_t b, word_t imm,
                                             word_t pc);
      case (op)
         ADD:        return a + b;
         ADDI, MEM:  return a + imm;
         SUB:        return a - b;
         AND:        return a & b;
         ANDI:       return a & imm;
         OR:         return a | b;
         ORI:        return a | imm;
         XOR:        return a ^ b;
         XORI:       return a ^ imm;
         SLL:        return a << b[SHW-1:0];
         SLLI:       return a << imm[SHW-1:0];
         SRL:        return a >> b[SHW-1:0];
         SRLI:       return a >> imm[SHW-1:0];
         SRA:        return shift_right_arith(a, b);
         SRAI:       return shift_right_arith(a, imm);
         SLT:        return word_t'(less_signed(a, b));
         SLTI:       return word_t'(less_signed(a, imm));
         SLTU:       return word_t'(a < b);
         SLTIU:      return word_t'(a < imm);
         LUI:        return imm;
         AUIPC:      return pc + imm;
         MUL:        return a * b;
         MULH:       return mul_high(a, b, 1'b1, 1'b1);
         MULHSU:     return mul_high(a, b, 1'b1, 1'b0);
         MULHU:      return mul_high(a, b, 1'b0, 1'b0);
         DIV:        return divide(a, b, 1'b1, 1'b0);
         DIVU:       return divide(a, b, 1'b0, 1'b0);
         REM:        return divide(a, b, 1'b1, 1'b1);
         REMU:       return divide(a, b, 1'b0, 1'b1);
         JAL, JALR:  return pc + 32'd4;
         default:    return '0;
      endcase
   endfunction

   function automatic word_t expected_target(ex_op_e op, word_t a, word_t imm, word_t pc);
      case (op)
         JAL:     return pc + imm;
         JALR:    return (a + imm) & ~word_t'(1);
         default: return '0;
      endcase
   endfunction

   // equal, signed less and unsigned less, in that bit order.
   function automatic logic [2:0] expected_flags(word_t a, word_t b);
      return {a == b, less_signed(a, b), a < b};
   endfunction

endpackage

// File: bench/ex_tb.sv
module ex_tb
   import ex_pkg::*;
   import ex_ref_pkg::*;
();

   localparam int RESET_CYCLES = 10;
   localparam int N_INT        = 2000;
   localparam int N_MULDIV     = 400;
   localparam int N_CORNER     = 8 * 6 * 6;
   localparam int N_JUMP       = 200;
   localparam int N_STALL      = 1000;
   localparam int N_DRAIN      = 4;
   localparam int TOTAL_CYCLES = RESET_CYCLES + N_INT + N_MULDIV + N_CORNER + N_JUMP
                                 + N_STALL + N_DRAIN + 1;
   localparam int TIMEOUT_CYCLES = 2 * TOTAL_CYCLES;

   localparam int G_INT    = 0;
   localparam int G_MULDIV = 1;
   localparam int G_JUMP   = 2;
   localparam int G_ANY    = 3;

   localparam ex_op_e INT_OPS [22] = '{ADD, ADDI, SUB, AUIPC, LUI, MEM, AND, ANDI, OR, ORI,
                                       XOR, XORI, SLL, SLLI, SRL, SRLI, SRA, SRAI, SLT, SLTI,
                                       SLTU, SLTIU};
   localparam ex_op_e MULDIV_OPS [8] = '{MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU};
   localparam word_t  CORNERS [6] = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff,
                                      32'h8000_0000, 32'h7fff_ffff, 32'h0000_0007};

   logic   clk_i;
   logic   rst_i;
   logic   stall_i;
   logic   valid_i;
   ex_op_e op_i;
   word_t  rs1_i;
   word_t  rs2_i;
   word_t  imm_i;
   word_t  pc_i;
   logic   ready_o;
   word_t  result_o;
   logic   redirect_o;
   word_t  target_o;
   logic   cmp_eq_o;
   logic   cmp_lt_o;
   logic   cmp_ltu_o;

   int    seed;
   int    cycle_cnt = 0;
   string test_name;
   word_t exp_q [$];
   logic  held_ready = 1'b0;
   word_t held_result = '0;
   logic  stall_seen = 1'b0;

   ex_top #(
      .XLEN(XLEN_DEF)
   ) u_dut (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .stall_i    (stall_i),
      .valid_i    (valid_i),
      .op_i       (op_i),
      .rs1_i      (rs1_i),
      .rs2_i      (rs2_i),
      .imm_i      (imm_i),
      .pc_i       (pc_i),
      .ready_o    (ready_o),
      .result_o   (result_o),
      .redirect_o (redirect_o),
      .target_o   (target_o),
      .cmp_eq_o   (cmp_eq_o),
      .cmp_lt_o   (cmp_lt_o),
      .cmp_ltu_o  (cmp_ltu_o)
   );

   initial clk_i = 1'b0;
   always #5 clk_i = ~clk_i;

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Testbench failed");
      $fatal(1, "run stopped at the first failure");
   endtask

   task automatic report_mismatch(input string what, input word_t expected, input word_t actual);
      fail_run($sformatf("** Error: test %s, %s: expected %h, actual %h",
                         test_name, what, expected, actual));
   endtask

   always @(posedge clk_i) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         fail_run($sformatf("timeout: the run did not finish within %0d cycles",
                            TIMEOUT_CYCLES));
      end
   end

   // inputs change on the rising edge, so the falling edge sees stable values.
   always @(negedge clk_i) begin : check_outputs
      word_t      exp_res;
      word_t      exp_tgt;
      logic       exp_rdy;
      logic       issued;
      logic       jump;
      logic [2:0] flags;
      if (stall_seen) begin
         exp_rdy = held_ready;
         exp_res = held_result;
      end else if (exp_q.size() != 0) begin
         exp_rdy = 1'b1;
         exp_res = exp_q.pop_front();
      end else begin
         exp_rdy = 1'b0;
         exp_res = held_result;
      end
      assert (ready_o === exp_rdy) else report_mismatch("ready_o", exp_rdy, ready_o);
      assert (result_o === exp_res) else report_mismatch("result_o", exp_res, result_o);
      held_ready  = exp_rdy;
      held_result = exp_res;

      issued  = valid_i && !stall_i;
      jump    = issued && (op_i == JAL || op_i == JALR);
      flags   = issued ? expected_flags(rs1_i, rs2_i) : 3'b000;
      exp_tgt = jump ? expected_target(op_i, rs1_i, imm_i, pc_i) : '0;
      assert ({cmp_eq_o, cmp_lt_o, cmp_ltu_o} === flags)
         else report_mismatch("compare flags", flags, {cmp_eq_o, cmp_lt_o, cmp_ltu_o});
      assert (redirect_o === jump) else report_mismatch("redirect_o", jump, redirect_o);
      assert (target_o === exp_tgt) else report_mismatch("target_o", exp_tgt, target_o);

      if (issued) begin
         exp_q.push_back(expected_result(op_i, rs1_i, rs2_i, imm_i, pc_i));
      end
      stall_seen = stall_i;
   end

   function automatic word_t random_operand();
      int unsigned kind;
      kind = $unsigned($random(seed)) % 8;
      case (kind)
         0:       return word_t'($random(seed) % 16);
         1:       return CORNERS[$unsigned($random(seed)) % 6];
         default: return word_t'($random(seed));
      endcase
   endfunction

   function automatic ex_op_e pick_op(input int group);
      int unsigned r;
      r = $unsigned($random(seed));
      case (group)
         G_INT:    return INT_OPS[r % 22];
         G_MULDIV: return MULDIV_OPS[r % 8];
         G_JUMP:   return (r % 2 == 0) ? JAL : JALR;
         default:  return ex_op_e'(r % 32);
      endcase
   endfunction

   task automatic drive_cycle(input logic valid, input logic stall, input ex_op_e op,
                              input word_t a, input word_t b, input word_t imm,
                              input word_t pc);
      @(posedge clk_i);
      valid_i <= valid;
      stall_i <= stall;
      op_i    <= op;
      rs1_i   <= a;
      rs2_i   <= b;
      imm_i   <= imm;
      pc_i    <= pc;
   endtask

   // valid three times in four, stall once in four where enabled.
   task automatic run_random(input string name, input int group, input int cycles,
                             input logic with_stall);
      int    i;
      word_t a;
      word_t b;
      logic  valid;
      logic  stall;
      test_name = name;
      for (i = 0; i < cycles; i++) begin
         a = random_operand();
         b = random_operand();
         if (($random(seed) & 7) == 0) begin
            b = a;
         end
         valid = ($random(seed) & 3) != 0;
         stall = with_stall && (($random(seed) & 3) == 0);
         drive_cycle(valid, stall, pick_op(group), a, b, random_operand(),
                     word_t'($random(seed)) & ~word_t'(3));
      end
   endtask

   task automatic run_corners();
      int i;
      int j;
      int k;
      test_name = "muldiv corners";
      for (k = 0; k < 8; k++) begin
         for (i = 0; i < 6; i++) begin
            for (j = 0; j < 6; j++) begin
               drive_cycle(1'b1, 1'b0, MULDIV_OPS[k], CORNERS[i], CORNERS[j], '0, '0);
            end
         end
      end
   endtask

   initial begin : stimulus
      seed      = 23691;
      test_name = "reset";
      rst_i     = 1'b0;
      stall_i   = 1'b0;
      valid_i   = 1'b0;
      op_i      = ADD;
      rs1_i     = '0;
      rs2_i     = '0;
      imm_i     = '0;
      pc_i      = '0;
      repeat (RESET_CYCLES) @(posedge clk_i);
      rst_i <= 1'b1;

      run_random("integer", G_INT, N_INT, 1'b0);
      run_random("muldiv random", G_MULDIV, N_MULDIV, 1'b0);
      run_corners();
      run_random("jump", G_JUMP, N_JUMP, 1'b0);
      run_random("stall", G_ANY, N_STALL, 1'b1);

      test_name = "drain";
      repeat (N_DRAIN) drive_cycle(1'b0, 1'b0, ADD, '0, '0, '0, '0);
      @(posedge clk_i);
      $display("Testbench passed");
      $finish;
   end

endmodule

// File: ex_top.f
source/ex_pkg.sv
source/ex_req_if.sv
source/alu_int.sv
source/alu_muldiv.sv
source/branch_jump_unit.sv
source/ex_stage.sv
source/ex_top.sv
bench/ex_ref_pkg.sv
bench/ex_tb.sv

// File: source/alu_int.sv
module alu_int
   import ex_pkg::*;
#(
   parameter int XLEN = XLEN_DEF
) (
   ex_req_if.consumer      req,
   output logic [XLEN-1:0] result_o
);

   localparam int SHW = $clog2(XLEN);

   logic                   use_imm;
   logic [XLEN-1:0]        op_b;
   logic [SHW-1:0]         shamt;
   logic signed [XLEN-1:0] sra_res;
   logic                   lt_s;
   logic                   lt_u;

   // immediate forms and address generation take imm as second operand.
   always_comb begin
      case (req.op)
         ADDI, ANDI, ORI, XORI, SLTI, SLTIU, MEM, SLLI, SRLI, SRAI: begin
            use_imm = 1'b1;
         end
         default: begin
            use_imm = 1'b0;
         end
      endcase
   end

   assign op_b  = use_imm ? req.imm : req.rs2;
   assign shamt = op_b[SHW-1:0];

   assign sra_res = $signed(req.rs1) >>> shamt;
   assign lt_s    = $signed(req.rs1) < $signed(op_b);
   assign lt_u    = req.rs1 < op_b;

   always_comb begin
      case (req.op)
         ADD, ADDI, MEM: begin
            result_o = req.rs1 + op_b;
         end
         SUB:         result_o = req.rs1 - op_b;
         AND, ANDI:   result_o = req.rs1 & op_b;
         OR, ORI:     result_o = req.rs1 | op_b;
         XOR, XORI:   result_o = req.rs1 ^ op_b;
         SLL, SLLI:   result_o = req.rs1 << shamt;
         SRL, SRLI:   result_o = req.rs1 >> shamt;
         SRA, SRAI:   result_o = sra_res;
         SLT, SLTI: begin
            result_o = {{(XLEN-1){1'b0}}, lt_s};
         end
         SLTU, SLTIU: begin
            result_o = {{(XLEN-1){1'b0}}, lt_u};
         end
         // imm already holds the shifted upper immediate.
         LUI:         result_o = req.imm;
         AUIPC:       result_o = req.pc + req.imm;
         default:     result_o = '0;
      endcase
   end

endmodule

// File: source/alu_muldiv.sv
module alu_muldiv
   import ex_pkg::*;
#(
   parameter int XLEN = XLEN_DEF
) (
   ex_req_if.consumer      req,
   output logic [XLEN-1:0] result_o
);

   localparam logic [XLEN-1:0] MOST_NEG = {1'b1, {(XLEN-1){1'b0}}};
   localparam logic [XLEN-1:0] ONE      = {{(XLEN-1){1'b0}}, 1'b1};

   logic                   a_signed;
   logic                   b_signed;
   logic [2*XLEN-1:0]      a_ext;
   logic [2*XLEN-1:0]      b_ext;
   logic [2*XLEN-1:0]      product;
   logic                   div_zero;
   logic                   div_ovf;
   logic signed [XLEN-1:0] s_divisor;
   logic signed [XLEN-1:0] s_quo;
   logic signed [XLEN-1:0] s_rem;
   logic [XLEN-1:0]        u_divisor;
   logic [XLEN-1:0]        u_quo;
   logic [XLEN-1:0]        u_rem;

   // one multiplier, operands extended to double width by signedness.
   assign a_signed = (req.op == MULH) || (req.op == MULHSU);
   assign b_signed = (req.op == MULH);

   assign a_ext = a_signed ? {{XLEN{req.rs1[XLEN-1]}}, req.rs1} : {{XLEN{1'b0}}, req.rs1};
   assign b_ext = b_signed ? {{XLEN{req.rs2[XLEN-1]}}, req.rs2} : {{XLEN{1'b0}}, req.rs2};

   assign product = a_ext * b_ext;

   assign div_zero = (req.rs2 == '0);
   assign div_ovf  = (req.rs1 == MOST_NEG) && (req.rs2 == '1);

   // dividing by one on overflow yields the dividend and a zero remainder.
   assign s_divisor = (div_zero || div_ovf) ? ONE : req.rs2;
   assign s_quo     = $signed(req.rs1) / s_divisor;
   assign s_rem     = $signed(req.rs1) % s_divisor;

   assign u_divisor = div_zero ? ONE : req.rs2;
   assign u_quo     = req.rs1 / u_divisor;
   assign u_rem     = req.rs1 % u_divisor;

   always_comb begin
      case (req.op)
         MUL: begin
            result_o = product[XLEN-1:0];
         end
         MULH, MULHSU, MULHU: begin
            result_o = product[2*XLEN-1:XLEN];
         end
         // division by zero gives all ones and the dividend.
         DIV:     result_o = div_zero ? '1 : s_quo;
         DIVU:    result_o = div_zero ? '1 : u_quo;
         REM:     result_o = div_zero ? req.rs1 : s_rem;
         REMU:    result_o = div_zero ? req.rs1 : u_rem;
         default: result_o = '0;
      endcase
   end

endmodule

// File: source/branch_jump_unit.sv
module branch_jump_unit
   import ex_pkg::*;
#(
   parameter int          XLEN    = XLEN_DEF,
   parameter int unsigned PC_STEP = ex_pkg::PC_STEP
) (
   ex_req_if.consumer      req,
   output logic [XLEN-1:0] link_o,
   output logic            redirect_o,
   output logic [XLEN-1:0] target_o,
   output logic            cmp_eq_o,
   output logic            cmp_lt_o,
   output logic            cmp_ltu_o
);

   logic            is_jump;
   logic [XLEN-1:0] jal_target;
   logic [XLEN-1:0] jalr_sum;

   assign is_jump = (req.op == JAL) || (req.op == JALR);

   assign link_o     = req.pc + XLEN'(PC_STEP);
   assign jal_target = req.pc + req.imm;
   assign jalr_sum   = req.rs1 + req.imm;

   assign redirect_o = req.valid && is_jump;

   // jalr target has bit 0 cleared.
   always_comb begin
      if (!redirect_o) begin
         target_o = '0;
      end else if (req.op == JALR) begin
         target_o = {jalr_sum[XLEN-1:1], 1'b0};
      end else begin
         target_o = jal_target;
      end
   end

   // flags feed branch resolution in the control unit.
   assign cmp_eq_o  = req.valid && (req.rs1 == req.rs2);
   assign cmp_lt_o  = req.valid && ($signed(req.rs1) < $signed(req.rs2));
   assign cmp_ltu_o = req.valid && (req.rs1 < req.rs2);

endmodule

// File: source/ex_pkg.sv
package ex_pkg;

   // default data width of the execute stage.
   localparam int XLEN_DEF = 32;

   // instruction size, added to the pc for the link address.
   localparam int unsigned PC_STEP = 4;

   // operation codes issued to the execute stage.
   // codes above SLTIU are unused and give a zero result.
   typedef enum logic [5:0] {
      ADD    = 6'd0,
      ADDI   = 6'd1,
      SUB    = 6'd2,
      // multiply.
      MUL    = 6'd3,
      MULH   = 6'd4,
      MULHSU = 6'd5,
      MULHU  = 6'd6,
      // divide and remainder.
      DIV    = 6'd7,
      DIVU   = 6'd8,
      REM    = 6'd9,
      REMU   = 6'd10,
      // upper immediate and jumps.
      AUIPC  = 6'd11,
      LUI    = 6'd12,
      JAL    = 6'd13,
      JALR   = 6'd14,
      // load and store address.
      MEM    = 6'd15,
      // logic.
      AND    = 6'd16,
      ANDI   = 6'd17,
      OR     = 6'd18,
      ORI    = 6'd19,
      XOR    = 6'd20,
      XORI   = 6'd21,
      // shifts.
      SLL    = 6'd22,
      SLLI   = 6'd23,
      SRL    = 6'd24,
      SRLI   = 6'd25,
      SRA    = 6'd26,
      SRAI   = 6'd27,
      // set less than.
      SLT    = 6'd28,
      SLTI   = 6'd29,
      SLTU   = 6'd30,
      SLTIU  = 6'd31
   } ex_op_e;

endpackage

// File: source/ex_req_if.sv
interface ex_req_if
   import ex_pkg::*;
#(
   parameter int XLEN = XLEN_DEF
);

   logic            valid;
   ex_op_e          op;
   logic [XLEN-1:0] rs1;
   logic [XLEN-1:0] rs2;
   logic [XLEN-1:0] imm;
   logic [XLEN-1:0] pc;

   // issue side, valid already masked by stall.
   modport producer (
      output valid, op, rs1, rs2, imm, pc
   );

   // functional unit side.
   modport consumer (
      input valid, op, rs1, rs2, imm, pc
   );

endinterface

// File: source/ex_stage.sv
module ex_stage
   import ex_pkg::*;
#(
   parameter int XLEN = XLEN_DEF
) (
   input  logic            clk_i,
   input  logic            rst_i,
   input  logic            stall_i,
   ex_req_if.consumer      req,
   output logic            ready_o,
   output logic [XLEN-1:0] result_o,
   output logic            redirect_o,
   output logic [XLEN-1:0] target_o,
   output logic            cmp_eq_o,
   output logic            cmp_lt_o,
   output logic            cmp_ltu_o
);

   typedef enum logic [1:0] {
      GRP_NONE,
      GRP_INT,
      GRP_MULDIV,
      GRP_JUMP
   } grp_e;

   grp_e            grp;
   logic [XLEN-1:0] int_res;
   logic [XLEN-1:0] md_res;
   logic [XLEN-1:0] link;
   logic [XLEN-1:0] result_sel;
   logic [XLEN-1:0] result_q;
   logic            ready_q;

   alu_int #(
      .XLEN(XLEN)
   ) u_alu_int (
      .req      (req),
      .result_o (int_res)
   );

   alu_muldiv #(
      .XLEN(XLEN)
   ) u_alu_muldiv (
      .req      (req),
      .result_o (md_res)
   );

   branch_jump_unit #(
      .XLEN    (XLEN),
      .PC_STEP (PC_STEP)
   ) u_branch_jump_unit (
      .req        (req),
      .link_o     (link),
      .redirect_o (redirect_o),
      .target_o   (target_o),
      .cmp_eq_o   (cmp_eq_o),
      .cmp_lt_o   (cmp_lt_o),
      .cmp_ltu_o  (cmp_ltu_o)
   );

   always_comb begin
      case (req.op)
         MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU: grp = GRP_MULDIV;
         JAL, JALR:                                      grp = GRP_JUMP;
         ADD, ADDI, SUB, AUIPC, LUI, MEM,
         AND, ANDI, OR, ORI, XOR, XORI,
         SLL, SLLI, SRL, SRLI, SRA, SRAI,
         SLT, SLTI, SLTU, SLTIU:                         grp = GRP_INT;
         default:                                        grp = GRP_NONE;
      endcase
   end

   always_comb begin
      case (grp)
         GRP_INT:    result_sel = int_res;
         GRP_MULDIV: result_sel = md_res;
         GRP_JUMP:   result_sel = link;
         default:    result_sel = '0;
      endcase
   end

   // unknown codes still raise ready with a zero result.
   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         ready_q  <= 1'b0;
         result_q <= '0;
      end else if (!stall_i) begin
         ready_q <= req.valid;
         if (req.valid) begin
            result_q <= result_sel;
         end
      end
   end

   assign ready_o  = ready_q;
   assign result_o = result_q;

   a_ready_after_valid: assert property (@(posedge clk_i) disable iff (!rst_i)
      $rose(ready_o) |-> $past(req.valid));

   a_redirect_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_i)
      redirect_o |-> (req.valid && !stall_i));

   a_hold_on_stall: assert property (@(posedge clk_i) disable iff (!rst_i)
      stall_i |=> ($stable(result_o) && $stable(ready_o)));

endmodule

// File: source/ex_top.sv
module ex_top
   import ex_pkg::*;
#(
   parameter int XLEN = XLEN_DEF
) (
   input  logic            clk_i,
   input  logic            rst_i,
   input  logic            stall_i,
   input  logic            valid_i,
   input  ex_op_e          op_i,
   input  logic [XLEN-1:0] rs1_i,
   input  logic [XLEN-1:0] rs2_i,
   input  logic [XLEN-1:0] imm_i,
   input  logic [XLEN-1:0] pc_i,
   output logic            ready_o,
   output logic [XLEN-1:0] result_o,
   output logic            redirect_o,
   output logic [XLEN-1:0] target_o,
   output logic            cmp_eq_o,
   output logic            cmp_lt_o,
   output logic            cmp_ltu_o
);

   ex_req_if #(
      .XLEN(XLEN)
   ) req_if ();

   // a stalled issue never reaches the functional units.
   assign req_if.valid = valid_i && !stall_i;
   assign req_if.op    = op_i;
   assign req_if.rs1   = rs1_i;
   assign req_if.rs2   = rs2_i;
   assign req_if.imm   = imm_i;
   assign req_if.pc    = pc_i;

   ex_stage #(
      .XLEN(XLEN)
   ) u_ex_stage (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .stall_i    (stall_i),
      .req        (req_if.consumer),
      .ready_o    (ready_o),
      .result_o   (result_o),
      .redirect_o (redirect_o),
      .target_o   (target_o),
      .cmp_eq_o   (cmp_eq_o),
      .cmp_lt_o   (cmp_lt_o),
      .cmp_ltu_o  (cmp_ltu_o)
   );

endmodule
